/* tb.f */
sib_pkg.sv
sib_ctrl.sv
sib_shuffler.sv
sib_poly_mem.sv
sib_top.sv
sib_assert.sv
tb_sib.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sib
FILELIST  = tb.f
BUILD_DIR = obj_dir
LOG       = sim.log
RUNFLAGS  = +verilator+error+limit+1000

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUNFLAGS) | tee $(LOG)
	grep -q "^Done: no errors$$" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* tb_sib.sv */
// Testbench for sib_top: random byte stream, reference SampleInBall model and full read-out check
`timescale 1ns/1ps

module tb_sib
  import sib_pkg::*;
;

  localparam int NUM_SAMPLERS    = 4;
  localparam int TAU             = 60;
  localparam int BEAT_W          = NUM_SAMPLERS * SIB_SAMPLE_W;
  localparam int CLK_PERIOD      = 10;
  localparam int RESET_CYCLES    = 16;
  localparam int NUM_RUNS        = 3;
  localparam int RUN_CYCLES      = 2000;
  localparam int WATCHDOG_CYCLES = RESET_CYCLES + NUM_RUNS * RUN_CYCLES;
  localparam logic [31:0] LFSR_SEED = 32'h15d0161a;

  logic              clk;
  logic              rst_b;
  logic              zeroize_i;
  logic              data_valid_i;
  logic [BEAT_W-1:0] data_i;
  logic              data_hold_o;
  logic              sib_done_o;
  word_addr_t        rd_addr_i;
  coeff_t [3:0]      rd_data_o;

  logic [31:0]       lfsr;
  logic [BEAT_W-1:0] beat_q [$];
  coeff_t            exp_poly [SIB_NUM_COEFF];
  int                check_errs;

  sib_top #(
    .SIB_NUM_SAMPLERS(NUM_SAMPLERS),
    .SIB_TAU         (TAU)
  ) i_dut (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .data_valid_i(data_valid_i),
    .data_i      (data_i),
    .data_hold_o (data_hold_o),
    .sib_done_o  (sib_done_o),
    .rd_addr_i   (rd_addr_i),
    .rd_data_o   (rd_data_o)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    logic fb;
    fb = s[31] ^ s[21] ^ s[1] ^ s[0];
    return {s[30:0], fb};
  endfunction

  function automatic logic [7:0] rand_bits(input int n);
    logic [7:0] bits;
    bits = '0;
    for (int k = 0; k < n; k++) begin
      lfsr = lfsr_next(lfsr);
      bits = {bits[6:0], lfsr[0]};
    end
    return bits;
  endfunction

  // Lane 0 sits in the low byte
  function automatic logic [BEAT_W-1:0] next_beat();
    logic [BEAT_W-1:0] beat;
    for (int l = 0; l < NUM_SAMPLERS; l++) begin
      beat[8*l +: 8] = rand_bits(8);
    end
    return beat;
  endfunction

  task automatic pulse_zeroize();
    @(posedge clk);
    zeroize_i    <= 1'b1;
    data_valid_i <= 1'b0;
    @(posedge clk);
    zeroize_i    <= 1'b0;
  endtask

  // Feed beats until done, recording each beat the DUT consumes
  task automatic run_stream();
    logic       took;
    logic       finished;
    logic [7:0] drop;
    beat_q.delete();
    finished = 1'b0;
    @(posedge clk);
    data_i       <= next_beat();
    data_valid_i <= 1'b1;
    while (!finished) begin
      @(negedge clk);
      if (sib_done_o) begin
        // The beat behind the last swap may still be held on the bus
        if (data_valid_i) begin
          beat_q.push_back(data_i);
        end
        finished = 1'b1;
      end else begin
        took = data_valid_i & ~data_hold_o;
        if (took) begin
          beat_q.push_back(data_i);
        end
        @(posedge clk);
        if (took) begin
          // Roughly one beat in four arrives a cycle late
          drop = rand_bits(2);
          data_i       <= next_beat();
          data_valid_i <= (drop != 8'd0);
        end else if (!data_valid_i) begin
          data_valid_i <= 1'b1;
        end
      end
    end
    // End of the first done cycle, where the last write lands
    @(posedge clk);
    data_valid_i <= 1'b0;
  endtask

  // Signs from the first two beats, then Fisher-Yates over accepted bytes
  function automatic void build_expected();
    logic [2*BEAT_W-1:0] sign_bits;
    logic [BEAT_W-1:0]   beat;
    int                  idx;
    int                  used;
    int                  j;
    for (int k = 0; k < SIB_NUM_COEFF; k++) begin
      exp_poly[k] = '0;
    end
    sign_bits = {beat_q[1], beat_q[0]};
    idx  = SIB_NUM_COEFF - TAU;
    used = 0;
    for (int b = 2; b < beat_q.size(); b++) begin
      beat = beat_q[b];
      for (int l = 0; l < NUM_SAMPLERS; l++) begin
        j = int'(beat[8*l +: 8]);
        if (idx < SIB_NUM_COEFF && j <= idx) begin
          exp_poly[idx] = exp_poly[j];
          exp_poly[j]   = sign_bits[used] ? COEFF_MINUS_ONE : COEFF_PLUS_ONE;
          used++;
          idx++;
        end
      end
    end
    if (idx != SIB_NUM_COEFF) begin
      $display("Reference model ran out of recorded beats at index %0d", idx);
      check_errs++;
    end
  endfunction

  task automatic check_readout(input int run_idx);
    coeff_t [3:0] want_w;
    int           nonzero;
    nonzero = 0;
    for (int w = 0; w < SIB_NUM_WORDS; w++) begin
      rd_addr_i <= word_addr_t'(w);
      @(posedge clk);
      @(negedge clk);
      for (int l = 0; l < 4; l++) begin
        want_w[l] = exp_poly[4*w + l];
        if (rd_data_o[l] != '0) begin
          nonzero++;
        end
        if (rd_data_o[l] != '0 && rd_data_o[l] != COEFF_PLUS_ONE &&
            rd_data_o[l] != COEFF_MINUS_ONE) begin
          $display("Run %0d: coefficient %0d holds %0d, which is not 0, 1 or q-1",
                   run_idx, 4*w + l, rd_data_o[l]);
          check_errs++;
        end
      end
      if (rd_data_o != want_w) begin
        $display("FAILED run%0d_readout word %0d: expected %h, actual %h",
                 run_idx, w, want_w, rd_data_o);
        check_errs++;
      end
      @(posedge clk);
    end
    if (nonzero != TAU) begin
      $display("FAILED run%0d_weight: expected %0d, actual %0d", run_idx, TAU, nonzero);
      check_errs++;
    end
  endtask

  initial begin
    lfsr         = LFSR_SEED;
    check_errs   = 0;
    rst_b        = 1'b0;
    zeroize_i    = 1'b0;
    data_valid_i = 1'b0;
    data_i       = '0;
    rd_addr_i    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_b <= 1'b1;
    for (int r = 0; r < NUM_RUNS; r++) begin
      pulse_zeroize();
      run_stream();
      build_expected();
      check_readout(r);
    end
    @(posedge clk);
    $display("Summary: %0d read-out errors, %0d assertion failures",
             check_errs, i_dut.i_assert.fail_cnt);
    if (check_errs == 0 && i_dut.i_assert.fail_cnt == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

  // Watchdog sized for reset plus all runs
  initial begin
    #(WATCHDOG_CYCLES * CLK_PERIOD);
    $display("Watchdog expired after %0d cycles, the runs did not finish", WATCHDOG_CYCLES);
    $display("Done: errors found");
    $finish;
  end

endmodule

/* sib_assert.sv */
// Bound checks for sib_top: done level, swap hold shape and zeroize clearing; bind to sib_top
`timescale 1ns/1ps

module sib_assert
  import sib_pkg::*;
(
  input logic         clk,
  input logic         rst_b,
  input logic         zeroize_i,
  input logic         data_hold_i,
  input logic         done_i,
  input logic         swap_valid_i,
  input sample_t      swap_idx_i,
  input logic         swap_hold_i,
  input coeff_t [3:0] rd_data_i
);

  int unsigned done_errs = 0;
  int unsigned swap_errs = 0;
  int unsigned zero_errs = 0;
  int unsigned fail_cnt;

  assign fail_cnt = done_errs + swap_errs + zero_errs;

  // Done is a level that only zeroize clears
  done_level: assert property (@(posedge clk) disable iff (!rst_b)
    done_i && !zeroize_i |=> done_i)
    else begin
      $error("sib_done_o dropped without zeroize");
      done_errs <= done_errs + 1;
    end

  done_no_hold: assert property (@(posedge clk) disable iff (!rst_b)
    done_i |-> !data_hold_i)
    else begin
      $error("data_hold_o high while sib_done_o is high");
      done_errs <= done_errs + 1;
    end

  // Shuffler holds one cycle, and only after a taken request
  hold_single: assert property (@(posedge clk) disable iff (!rst_b)
    swap_hold_i |=> !swap_hold_i)
    else begin
      $error("swap_hold lasted more than one cycle");
      swap_errs <= swap_errs + 1;
    end

  hold_after_take: assert property (@(posedge clk) disable iff (!rst_b)
    swap_hold_i |-> $past(swap_valid_i && !swap_hold_i))
    else begin
      $error("swap_hold rose without a taken swap request");
      swap_errs <= swap_errs + 1;
    end

  // The index i only advances on a request the shuffler took
  hold_no_take: assert property (@(posedge clk) disable iff (!rst_b)
    swap_hold_i && !zeroize_i |=> $stable(swap_idx_i))
    else begin
      $error("swap index advanced while swap_hold was high");
      swap_errs <= swap_errs + 1;
    end

  zeroize_clears: assert property (@(posedge clk) disable iff (!rst_b)
    zeroize_i |=> !done_i && rd_data_i == '0)
    else begin
      $error("zeroize left sib_done_o or the read-out word nonzero");
      zero_errs <= zero_errs + 1;
    end

endmodule

bind sib_top sib_assert i_assert (
  .clk         (clk),
  .rst_b       (rst_b),
  .zeroize_i   (zeroize_i),
  .data_hold_i (data_hold_o),
  .done_i      (sib_done_o),
  .swap_valid_i(swap_valid),
  .swap_idx_i  (swap_i),
  .swap_hold_i (swap_hold),
  .rd_data_i   (rd_data_o)
);

/* sib_top.sv */
// SampleInBall top level; sets the lane count and tau and wires controller, shuffler and memory
`timescale 1ns/1ps

module sib_top
  import sib_pkg::*;
#(
  parameter int SIB_NUM_SAMPLERS = 4,
  parameter int SIB_TAU          = 60
) (
  input  logic                           clk,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  logic                           data_valid_i,
  input  sample_t [SIB_NUM_SAMPLERS-1:0] data_i,
  output logic                           data_hold_o,
  output logic                           sib_done_o,
  input  word_addr_t                     rd_addr_i,
  output coeff_t [3:0]                   rd_data_o
);

  // Swap request channel
  logic    swap_valid;
  sample_t swap_i;
  sample_t swap_j;
  logic    swap_sign;
  logic    swap_hold;

  // Memory ports used by the shuffler
  logic [1:0]        we;
  word_addr_t [1:0]  addr;
  coeff_t [1:0][3:0] wrdata;
  coeff_t [1:0][3:0] rddata;

  sib_ctrl #(
    .SIB_NUM_SAMPLERS(SIB_NUM_SAMPLERS),
    .SIB_TAU         (SIB_TAU)
  ) i_ctrl (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .data_valid_i(data_valid_i),
    .data_i      (data_i),
    .data_hold_o (data_hold_o),
    .sib_done_o  (sib_done_o),
    .swap_valid_o(swap_valid),
    .swap_i_o    (swap_i),
    .swap_j_o    (swap_j),
    .swap_sign_o (swap_sign),
    .swap_hold_i (swap_hold)
  );

  sib_shuffler i_shuffler (
    .clk         (clk),
    .rst_b       (rst_b),
    .zeroize_i   (zeroize_i),
    .swap_valid_i(swap_valid),
    .swap_i_i    (swap_i),
    .swap_j_i    (swap_j),
    .swap_sign_i (swap_sign),
    .swap_hold_o (swap_hold),
    .we_o        (we),
    .addr_o      (addr),
    .wrdata_o    (wrdata),
    .rddata_i    (rddata)
  );

  sib_poly_mem i_mem (
    .clk      (clk),
    .rst_b    (rst_b),
    .zeroize_i(zeroize_i),
    .we_i     (we),
    .addr_i   (addr),
    .wrdata_i (wrdata),
    .rddata_o (rddata),
    .rd_addr_i(rd_addr_i),
    .rd_data_o(rd_data_o)
  );

endmodule

/* sib_poly_mem.sv */
// Coefficient store for the challenge polynomial, two swap ports plus a registered read-out port
`timescale 1ns/1ps

module sib_poly_mem
  import sib_pkg::*;
(
  input  logic              clk,
  input  logic              rst_b,
  input  logic              zeroize_i,
  input  logic [1:0]        we_i,
  input  word_addr_t [1:0]  addr_i,
  input  coeff_t [1:0][3:0] wrdata_i,
  output coeff_t [1:0][3:0] rddata_o,
  input  word_addr_t        rd_addr_i,
  output coeff_t [3:0]      rd_data_o
);

  coeff_t [3:0] mem [SIB_NUM_WORDS];

  // Port 0 is written last so it wins a same-word collision
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      for (int w = 0; w < SIB_NUM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else if (zeroize_i) begin
      for (int w = 0; w < SIB_NUM_WORDS; w++) begin
        mem[w] <= '0;
      end
    end else begin
      if (we_i[1]) begin
        mem[addr_i[1]] <= wrdata_i[1];
      end
      if (we_i[0]) begin
        mem[addr_i[0]] <= wrdata_i[0];
      end
    end
  end

  // Swap ports return the old word one cycle after the address
  always_ff @(posedge clk) begin
    for (int p = 0; p < 2; p++) begin
      rddata_o[p] <= mem[addr_i[p]];
    end
  end

  // Read-out port
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rd_data_o <= '0;
    end else if (zeroize_i) begin
      rd_data_o <= '0;
    end else begin
      rd_data_o <= mem[rd_addr_i];
    end
  end

endmodule

/* sib_shuffler.sv */
// Fisher-Yates swap engine: one read cycle and one write cycle per request from the controller
`timescale 1ns/1ps

module sib_shuffler
  import sib_pkg::*;
(
  input  logic             clk,
  input  logic             rst_b,
  input  logic             zeroize_i,
  input  logic             swap_valid_i,
  input  sample_t          swap_i_i,
  input  sample_t          swap_j_i,
  input  logic             swap_sign_i,
  output logic             swap_hold_o,
  output logic [1:0]       we_o,
  output word_addr_t [1:0] addr_o,
  output coeff_t [1:0][3:0] wrdata_o,
  input  coeff_t [1:0][3:0] rddata_i
);

  logic         busy;
  logic         swap_take;
  sample_t      idx_i_q;
  sample_t      idx_j_q;
  logic         sign_q;
  word_addr_t   word_i_q;
  word_addr_t   word_j_q;
  logic [1:0]   lane_i_q;
  logic [1:0]   lane_j_q;
  logic         same_word;
  coeff_t       old_cj;
  coeff_t       sign_val;
  coeff_t [3:0] word_i_new;
  coeff_t [3:0] word_j_new;
  coeff_t [3:0] word_merged;

  assign swap_take   = swap_valid_i & ~busy;
  assign swap_hold_o = busy;

  // Busy for exactly the write cycle after a take
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      busy <= 1'b0;
    end else if (zeroize_i) begin
      busy <= 1'b0;
    end else begin
      busy <= swap_take;
    end
  end

  always_ff @(posedge clk) begin
    if (swap_take) begin
      idx_i_q <= swap_i_i;
      idx_j_q <= swap_j_i;
      sign_q  <= swap_sign_i;
    end
  end

  assign word_i_q  = word_addr_t'(idx_i_q >> 2);
  assign word_j_q  = word_addr_t'(idx_j_q >> 2);
  assign lane_i_q  = idx_i_q[1:0];
  assign lane_j_q  = idx_j_q[1:0];
  assign same_word = (word_i_q == word_j_q);

  // Read both words on the take cycle, write back to the same words next cycle
  always_comb begin
    if (busy) begin
      addr_o[0] = word_i_q;
      addr_o[1] = word_j_q;
    end else begin
      addr_o[0] = word_addr_t'(swap_i_i >> 2);
      addr_o[1] = word_addr_t'(swap_j_i >> 2);
    end
  end

  assign old_cj   = rddata_i[1][lane_j_q];
  assign sign_val = sign_q ? COEFF_MINUS_ONE : COEFF_PLUS_ONE;

  // c[i] gets old c[j], then c[j] gets the sign; with i == j the sign wins
  always_comb begin
    word_i_new               = rddata_i[0];
    word_i_new[lane_i_q]     = old_cj;
    word_j_new               = rddata_i[1];
    word_j_new[lane_j_q]     = sign_val;
    word_merged              = word_i_new;
    word_merged[lane_j_q]    = sign_val;
  end

  always_comb begin
    we_o        = busy ? (same_word ? 2'b01 : 2'b11) : 2'b00;
    wrdata_o[0] = same_word ? word_merged : word_i_new;
    wrdata_o[1] = word_j_new;
  end

endmodule

/* sib_ctrl.sv */
// SampleInBall controller: gathers sign bits, rejects candidate bytes and issues swap requests
`timescale 1ns/1ps

module sib_ctrl
  import sib_pkg::*;
#(
  parameter int SIB_NUM_SAMPLERS = 4,
  parameter int SIB_TAU          = 60
) (
  input  logic                           clk,
  input  logic                           rst_b,
  input  logic                           zeroize_i,
  input  logic                           data_valid_i,
  input  sample_t [SIB_NUM_SAMPLERS-1:0] data_i,
  output logic                           data_hold_o,
  output logic                           sib_done_o,
  output logic                           swap_valid_o,
  output sample_t                        swap_i_o,
  output sample_t                        swap_j_o,
  output logic                           swap_sign_o,
  input  logic                           swap_hold_i
);

  // SIB_TAU has to fit in two beats
  localparam int DATA_BITS = SIB_NUM_SAMPLERS * SIB_SAMPLE_W;
  localparam int LANE_W    = (SIB_NUM_SAMPLERS > 1) ? $clog2(SIB_NUM_SAMPLERS) : 1;
  localparam logic [LANE_W-1:0] LAST_LANE = LANE_W'(SIB_NUM_SAMPLERS - 1);

  sib_fsm_state_e              state;
  sib_fsm_state_e              state_nxt;
  logic                        in_active;
  logic [SIB_TAU-1:0]          sign_buf;
  logic [2*DATA_BITS-1:0]      sign_nxt;
  logic                        sign_load;
  logic                        sign_hi;
  sample_t                     rej_value;
  logic [SIB_NUM_SAMPLERS-1:0] lane_ok;
  logic [SIB_NUM_SAMPLERS-1:0] lane_mask;
  logic [SIB_NUM_SAMPLERS-1:0] lane_mask_nxt;
  logic                        index_found;
  logic [LANE_W-1:0]           valid_index;
  logic                        lane_hold;
  logic                        swap_take;
  logic                        beat_take;
  logic                        last_take;

  // Per-lane rejection against the running index i
  always_comb begin
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      lane_ok[k] = lane_mask[k] & data_valid_i & (data_i[k] <= rej_value);
    end
  end

  // First accepted lane; the lanes up to it are dropped from the beat
  always_comb begin
    index_found   = 1'b0;
    valid_index   = '0;
    lane_mask_nxt = lane_mask;
    for (int k = 0; k < SIB_NUM_SAMPLERS; k++) begin
      if (!index_found) begin
        lane_mask_nxt[k] = 1'b0;
        if (lane_ok[k]) begin
          index_found = 1'b1;
          valid_index = LANE_W'(k);
        end
      end
    end
  end

  always_comb begin
    state_nxt = state;
    unique case (state)
      SIB_IDLE: begin
        if (data_valid_i) state_nxt = SIB_SIGN_BUFFER;
      end
      SIB_SIGN_BUFFER: begin
        if (data_valid_i) state_nxt = SIB_ACTIVE;
      end
      SIB_ACTIVE: begin
        if (last_take) state_nxt = SIB_DONE;
      end
      SIB_DONE: begin
        state_nxt = SIB_DONE;
      end
      default: begin
        state_nxt = SIB_IDLE;
      end
    endcase
  end

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      state <= SIB_IDLE;
    end else if (zeroize_i) begin
      state <= SIB_IDLE;
    end else begin
      state <= state_nxt;
    end
  end

  assign in_active  = (state == SIB_ACTIVE);
  assign sib_done_o = (state == SIB_DONE);

  // Swap handshake
  assign swap_valid_o = in_active & index_found;
  assign swap_take    = swap_valid_o & ~swap_hold_i;
  assign swap_i_o     = rej_value;
  assign swap_j_o     = data_i[valid_index];
  assign swap_sign_o  = sign_buf[0];
  assign last_take    = swap_take & (&rej_value);

  // Keep the beat while later lanes remain or the shuffler is busy
  assign lane_hold   = index_found & (valid_index != LAST_LANE);
  assign data_hold_o = in_active & (lane_hold | (index_found & swap_hold_i));
  assign beat_take   = data_valid_i & ~data_hold_o;

  // Sign buffer, beat 1 in the low bits and beat 2 above it
  assign sign_load = data_valid_i & ((state == SIB_IDLE) | (state == SIB_SIGN_BUFFER));
  assign sign_hi   = (state == SIB_SIGN_BUFFER);
  assign sign_nxt  = sign_hi ? {data_i, {DATA_BITS{1'b0}}} : {{DATA_BITS{1'b0}}, data_i};

  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      sign_buf <= '0;
    end else if (zeroize_i) begin
      sign_buf <= '0;
    end else if (sign_load) begin
      sign_buf <= sign_buf | sign_nxt[SIB_TAU-1:0];
    end else if (swap_take) begin
      sign_buf <= sign_buf >> 1;
    end
  end

  // Running index starts at 256 - tau, one step per taken swap
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      rej_value <= sample_t'(SIB_NUM_COEFF - SIB_TAU);
    end else if (zeroize_i) begin
      rej_value <= sample_t'(SIB_NUM_COEFF - SIB_TAU);
    end else if (swap_take) begin
      rej_value <= rej_value + 1'b1;
    end
  end

  // Lane mask, reopened whenever a new beat arrives
  always_ff @(posedge clk or negedge rst_b) begin
    if (!rst_b) begin
      lane_mask <= '1;
    end else if (zeroize_i) begin
      lane_mask <= '1;
    end else if (in_active & beat_take) begin
      lane_mask <= '1;
    end else if (swap_take & lane_hold) begin
      lane_mask <= lane_mask_nxt;
    end
  end

endmodule

/* sib_pkg.sv */
// Shared widths, state encoding and modulus constants for the SampleInBall engine; import by wildcard
package sib_pkg;

  // Dilithium modulus q
  localparam int unsigned DILITHIUM_Q = 32'd8380417;

  // Coefficient width, enough for q-1
  localparam int COEFF_W = 23;

  // Polynomial size and candidate byte width
  localparam int SIB_NUM_COEFF = 256;
  localparam int SIB_SAMPLE_W  = 8;

  // Four coefficients per memory word
  localparam int SIB_COEFF_PER_WORD = 4;
  localparam int SIB_NUM_WORDS      = SIB_NUM_COEFF / SIB_COEFF_PER_WORD;

  typedef logic [COEFF_W-1:0]      coeff_t;
  typedef logic [SIB_SAMPLE_W-1:0] sample_t;
  typedef logic [5:0]              word_addr_t;

  // Values of a nonzero coefficient, minus one is stored as q-1
  localparam coeff_t COEFF_PLUS_ONE  = coeff_t'(1);
  localparam coeff_t COEFF_MINUS_ONE = coeff_t'(DILITHIUM_Q - 1);

  // Controller states
  typedef enum logic [1:0] {
    SIB_IDLE        = 2'd0,
    SIB_SIGN_BUFFER = 2'd1,
    SIB_ACTIVE      = 2'd2,
    SIB_DONE        = 2'd3
  } sib_fsm_state_e;

endpackage
